/* hdl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // fixed by the RISC-V register file
    localparam int LREG_W   = 5;
    localparam int NUM_LREG = 32;

    // sized for the default 64 physical registers
    localparam int PREG_W   = 6;

    typedef logic [LREG_W-1:0] lreg_t;
    typedef logic [PREG_W-1:0] preg_t;

    // decoded instruction trimmed to what rename and dispatch need
    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
        logic [31:0] instr;
        logic [63:0] imm;
        lreg_t       lrs1;
        lreg_t       lrs2;
        lreg_t       lrd;
        logic        src1_is_reg;
        logic        src2_is_reg;
        logic        need_to_wb;
        logic        is_load;
        logic        is_store;
        logic [3:0]  alu_type;
    } decoded_instr_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
        logic [31:0] instr;
        logic [63:0] imm;
        lreg_t       lrs1;
        lreg_t       lrs2;
        lreg_t       lrd;
        logic        src1_is_reg;
        logic        src2_is_reg;
        logic        need_to_wb;
        logic        is_load;
        logic        is_store;
        logic [3:0]  alu_type;
        // physical mappings filled in by rename
        preg_t       prs1;
        preg_t       prs2;
        preg_t       prd;
        preg_t       old_prd;
    } renamed_instr_t;

    // the two slots always move as one group
    typedef struct packed {
        decoded_instr_t slot0;
        decoded_instr_t slot1;
    } decoded_pair_t;

    typedef struct packed {
        renamed_instr_t slot0;
        renamed_instr_t slot1;
    } renamed_pair_t;

endpackage

`default_nettype wire

/* hdl/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire      clock,
    input  wire      rst_n,
    input  wire      flush,
    input  wire      in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    payload_t data_q;
    logic     valid_q;

    // room when empty or when the held group leaves this cycle
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only loads on an accepted transfer
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/hazard_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_checker
    import rename_pkg::*;
(
    input  decoded_instr_t instr0,
    input  decoded_instr_t instr1,
    output logic           raw_rs1,
    output logic           raw_rs2,
    output logic           waw
);

    logic both_valid;
    logic instr0_writes;
    logic instr1_writes;

    assign both_valid    = instr0.valid && instr1.valid;
    assign instr0_writes = both_valid && instr0.need_to_wb;
    assign instr1_writes = both_valid && instr1.need_to_wb;

    // slot 1 reads what slot 0 is about to produce
    assign raw_rs1 = instr0_writes && instr1.src1_is_reg
                     && (instr1.lrs1 == instr0.lrd);
    assign raw_rs2 = instr0_writes && instr1.src2_is_reg
                     && (instr1.lrs2 == instr0.lrd);

    // both slots target the same logical register
    assign waw = instr0_writes && instr1_writes && (instr1.lrd == instr0.lrd);

endmodule

`default_nettype wire

/* hdl/spec_rat.sv */
`timescale 1ns/1ps
`default_nettype none

module spec_rat
    import rename_pkg::*;
(
    input  wire              clock,
    input  wire              rst_n,
    input  wire              flush,
    // six lookups per cycle, three per slot
    input  wire  [5:0]       rd_en,
    input  lreg_t [5:0]      rd_idx,
    output preg_t [5:0]      rd_data,
    // one new mapping per slot
    input  wire  [1:0]       wr_en,
    input  lreg_t [1:0]      wr_idx,
    input  preg_t [1:0]      wr_data
);

    preg_t map_q [NUM_LREG];

    // asynchronous reads, zero when the port is idle
    always_comb begin
        for (int p = 0; p < 6; p++) begin
            rd_data[p] = rd_en[p] ? map_q[rd_idx[p]] : '0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LREG; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (flush) begin
            // back to identity mapping
            for (int i = 0; i < NUM_LREG; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else begin
            if (wr_en[0]) begin
                map_q[wr_idx[0]] <= wr_data[0];
            end
            // slot 1 is younger, so it lands last
            if (wr_en[1]) begin
                map_q[wr_idx[1]] <= wr_data[1];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list
    import rename_pkg::*;
#(
    parameter int NUM_PREG = 64
) (
    input  wire   clock,
    input  wire   rst_n,
    input  wire   flush,
    input  wire   alloc0,
    input  wire   alloc1,
    input  wire   release_valid,
    input  preg_t release_preg,
    output preg_t free0,
    output preg_t free1,
    output logic  can_alloc
);

    localparam int DEPTH = NUM_PREG - NUM_LREG;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    preg_t             queue_q [DEPTH];
    logic [PTR_W-1:0]  head_q;
    logic [PTR_W-1:0]  tail_q;
    logic [CNT_W-1:0]  count_q;
    logic [1:0]        n_pop;

    // circular pointer advance
    function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] p,
                                                   input int unsigned n);
        int unsigned s;
        s = int'(p) + n;
        if (s >= DEPTH) begin
            s = s - DEPTH;
        end
        return PTR_W'(s);
    endfunction

    assign n_pop     = {1'b0, alloc0} + {1'b0, alloc1};
    assign can_alloc = (count_q >= CNT_W'(2));

    // a lone slot 1 allocation takes the head entry
    assign free0 = queue_q[head_q];
    assign free1 = alloc0 ? queue_q[ptr_step(head_q, 1)] : queue_q[head_q];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                queue_q[i] <= preg_t'(NUM_LREG + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(DEPTH);
        end else if (flush) begin
            // refill with the registers above the logical range
            for (int i = 0; i < DEPTH; i++) begin
                queue_q[i] <= preg_t'(NUM_LREG + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(DEPTH);
        end else begin
            if (release_valid) begin
                queue_q[tail_q] <= release_preg;
                tail_q          <= ptr_step(tail_q, 1);
            end
            head_q  <= ptr_step(head_q, n_pop);
            count_q <= count_q + CNT_W'(release_valid) - CNT_W'(n_pop);
        end
    end

endmodule

`default_nettype wire

/* hdl/rename.sv */
`timescale 1ns/1ps
`default_nettype none

module rename
    import rename_pkg::*;
(
    input  decoded_pair_t  dec_q,
    input  wire            dec_q_valid,
    output logic           in_ready,
    input  wire            out_ready,
    // spec_rat ports
    output logic  [5:0]    rat_rd_en,
    output lreg_t [5:0]    rat_rd_idx,
    input  preg_t [5:0]    rat_rd_data,
    output logic  [1:0]    rat_wr_en,
    output lreg_t [1:0]    rat_wr_idx,
    output preg_t [1:0]    rat_wr_data,
    // free list ports
    output logic           alloc0,
    output logic           alloc1,
    input  preg_t          free0,
    input  preg_t          free1,
    input  wire            can_alloc,
    // towards the output register
    output logic           rn_valid,
    output renamed_pair_t  rn_d
);

    logic fire;
    logic wb0;
    logic wb1;
    logic raw_rs1;
    logic raw_rs2;
    logic waw;

    // copy the fields that pass through unchanged
    function automatic renamed_instr_t carry(input decoded_instr_t d);
        renamed_instr_t r;
        r             = '0;
        r.valid       = d.valid;
        r.pc          = d.pc;
        r.instr       = d.instr;
        r.imm         = d.imm;
        r.lrs1        = d.lrs1;
        r.lrs2        = d.lrs2;
        r.lrd         = d.lrd;
        r.src1_is_reg = d.src1_is_reg;
        r.src2_is_reg = d.src2_is_reg;
        r.need_to_wb  = d.need_to_wb;
        r.is_load     = d.is_load;
        r.is_store    = d.is_store;
        r.alu_type    = d.alu_type;
        return r;
    endfunction

    hazard_checker u_hazard_checker (
        .instr0  (dec_q.slot0),
        .instr1  (dec_q.slot1),
        .raw_rs1 (raw_rs1),
        .raw_rs2 (raw_rs2),
        .waw     (waw)
    );

    // stall without allocating when fewer than two registers are free
    assign in_ready = out_ready && can_alloc;
    assign rn_valid = dec_q_valid && can_alloc;
    assign fire     = dec_q_valid && in_ready;

    assign wb0 = dec_q.slot0.valid && dec_q.slot0.need_to_wb;
    assign wb1 = dec_q.slot1.valid && dec_q.slot1.need_to_wb;

    // ports 0..2 serve slot 0, ports 3..5 serve slot 1
    assign rat_rd_en  = {wb1, dec_q.slot1.valid && dec_q.slot1.src2_is_reg,
                         dec_q.slot1.valid && dec_q.slot1.src1_is_reg,
                         wb0, dec_q.slot0.valid && dec_q.slot0.src2_is_reg,
                         dec_q.slot0.valid && dec_q.slot0.src1_is_reg};
    assign rat_rd_idx = {dec_q.slot1.lrd, dec_q.slot1.lrs2, dec_q.slot1.lrs1,
                         dec_q.slot0.lrd, dec_q.slot0.lrs2, dec_q.slot0.lrs1};

    assign alloc0 = fire && wb0;
    assign alloc1 = fire && wb1;

    // slot 1 overwrites the same mapping, so slot 0's write is dropped
    assign rat_wr_en   = {alloc1, alloc0 && !waw};
    assign rat_wr_idx  = {dec_q.slot1.lrd, dec_q.slot0.lrd};
    assign rat_wr_data = {free1, free0};

    always_comb begin
        rn_d.slot0         = carry(dec_q.slot0);
        rn_d.slot0.prs1    = rat_rd_data[0];
        rn_d.slot0.prs2    = rat_rd_data[1];
        rn_d.slot0.prd     = wb0 ? free0 : '0;
        rn_d.slot0.old_prd = rat_rd_data[2];

        rn_d.slot1         = carry(dec_q.slot1);
        rn_d.slot1.prs1    = raw_rs1 ? free0 : rat_rd_data[3];
        rn_d.slot1.prs2    = raw_rs2 ? free0 : rat_rd_data[4];
        rn_d.slot1.prd     = wb1 ? free1 : '0;
        // slot 1 replaces the mapping slot 0 just made
        rn_d.slot1.old_prd = waw ? free0 : rat_rd_data[5];
    end

endmodule

`default_nettype wire

/* hdl/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_top
    import rename_pkg::*;
#(
    parameter int NUM_PREG = 64
) (
    input  wire           clock,
    input  wire           rst_n,
    input  wire           dec_valid,
    output logic          dec_ready,
    input  decoded_pair_t dec_pair,
    output logic          rn_valid,
    input  wire           rn_ready,
    output renamed_pair_t rn_pair,
    input  wire           flush_valid,
    input  wire           release_valid,
    input  preg_t         release_preg
);

    decoded_pair_t dec_q;
    logic          dec_q_valid;
    logic          rename_ready;
    logic          out_reg_ready;
    logic          rn_d_valid;
    renamed_pair_t rn_d;

    logic  [5:0]   rat_rd_en;
    lreg_t [5:0]   rat_rd_idx;
    preg_t [5:0]   rat_rd_data;
    logic  [1:0]   rat_wr_en;
    lreg_t [1:0]   rat_wr_idx;
    preg_t [1:0]   rat_wr_data;

    logic          alloc0;
    logic          alloc1;
    preg_t         free0;
    preg_t         free1;
    logic          can_alloc;

    // decoded pair register in front of rename
    pipe_reg #(.payload_t(decoded_pair_t)) u_dec_reg (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush_valid),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (dec_pair),
        .out_valid (dec_q_valid),
        .out_ready (rename_ready),
        .out_data  (dec_q)
    );

    rename u_rename (
        .dec_q       (dec_q),
        .dec_q_valid (dec_q_valid),
        .in_ready    (rename_ready),
        .out_ready   (out_reg_ready),
        .rat_rd_en   (rat_rd_en),
        .rat_rd_idx  (rat_rd_idx),
        .rat_rd_data (rat_rd_data),
        .rat_wr_en   (rat_wr_en),
        .rat_wr_idx  (rat_wr_idx),
        .rat_wr_data (rat_wr_data),
        .alloc0      (alloc0),
        .alloc1      (alloc1),
        .free0       (free0),
        .free1       (free1),
        .can_alloc   (can_alloc),
        .rn_valid    (rn_d_valid),
        .rn_d        (rn_d)
    );

    spec_rat u_spec_rat (
        .clock   (clock),
        .rst_n   (rst_n),
        .flush   (flush_valid),
        .rd_en   (rat_rd_en),
        .rd_idx  (rat_rd_idx),
        .rd_data (rat_rd_data),
        .wr_en   (rat_wr_en),
        .wr_idx  (rat_wr_idx),
        .wr_data (rat_wr_data)
    );

    free_list #(.NUM_PREG(NUM_PREG)) u_free_list (
        .clock         (clock),
        .rst_n         (rst_n),
        .flush         (flush_valid),
        .alloc0        (alloc0),
        .alloc1        (alloc1),
        .release_valid (release_valid),
        .release_preg  (release_preg),
        .free0         (free0),
        .free1         (free1),
        .can_alloc     (can_alloc)
    );

    // renamed pair register feeding dispatch
    pipe_reg #(.payload_t(renamed_pair_t)) u_rn_reg (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush_valid),
        .in_valid  (rn_d_valid),
        .in_ready  (out_reg_ready),
        .in_data   (rn_d),
        .out_valid (rn_valid),
        .out_ready (rn_ready),
        .out_data  (rn_pair)
    );

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic rst_n
);

    localparam int HALF_NS = PERIOD_NS / 2;

    initial begin
        clock = 1'b0;
        forever #(HALF_NS) clock = ~clock;
    end

    // release on a falling edge so the first stimulus edge is clean
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/tb_rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_top
    import rename_pkg::*;
();

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int NUM_PREG      = 64;
    // per-test cycle budgets in test order, then a margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 + 30 + 30 + 40 + 120 + 40 + 100;

    logic          clock;
    logic          rst_n;
    logic          dec_valid;
    logic          dec_ready;
    decoded_pair_t dec_pair;
    logic          rn_valid;
    logic          rn_ready;
    renamed_pair_t rn_pair;
    logic          flush_valid;
    logic          release_valid;
    preg_t         release_preg;

    // reference model of the table and the free list
    preg_t         model_rat [NUM_LREG];
    preg_t         free_q [$];
    decoded_pair_t sent_q [$];
    preg_t         retire_q [$];
    bit            in_use [NUM_PREG];
    renamed_pair_t last_rx;
    int            recv_count = 0;
    int            seed = 32'ha4cb;
    logic [63:0]   pc_next = 64'h8000_0000;

    clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    rename_top #(.NUM_PREG(NUM_PREG)) UUT (
        .clock         (clock),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .dec_pair      (dec_pair),
        .rn_valid      (rn_valid),
        .rn_ready      (rn_ready),
        .rn_pair       (rn_pair),
        .flush_valid   (flush_valid),
        .release_valid (release_valid),
        .release_preg  (release_preg)
    );

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_value(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_value($sformatf("%s: got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_preg(input preg_t got, input preg_t exp, input string what);
        if (got !== exp) begin
            fail_value($sformatf("%s: got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_pair(input renamed_pair_t got, input renamed_pair_t exp,
                              input string what);
        renamed_instr_t g [2];
        renamed_instr_t e [2];
        g[0] = got.slot0;
        g[1] = got.slot1;
        e[0] = exp.slot0;
        e[1] = exp.slot1;
        for (int s = 0; s < 2; s++) begin
            check_preg(g[s].prs1, e[s].prs1, $sformatf("%s slot%0d prs1", what, s));
            check_preg(g[s].prs2, e[s].prs2, $sformatf("%s slot%0d prs2", what, s));
            check_preg(g[s].prd, e[s].prd, $sformatf("%s slot%0d prd", what, s));
            check_preg(g[s].old_prd, e[s].old_prd, $sformatf("%s slot%0d old_prd", what, s));
            if (g[s] !== e[s]) begin
                fail_value($sformatf("%s slot%0d payload: got %h expected %h",
                                     what, s, g[s], e[s]));
            end
        end
    endtask

    task automatic reset_model();
        free_q.delete();
        sent_q.delete();
        retire_q.delete();
        for (int i = 0; i < NUM_LREG; i++) begin
            model_rat[i] = preg_t'(i);
        end
        for (int i = NUM_LREG; i < NUM_PREG; i++) begin
            free_q.push_back(preg_t'(i));
        end
        // logical identity registers start out mapped
        for (int i = 0; i < NUM_PREG; i++) begin
            in_use[i] = (i < NUM_LREG);
        end
    endtask

    // a slot sees the table as left by the older slot
    function automatic renamed_instr_t predict_slot(input decoded_instr_t d);
        renamed_instr_t r;
        r = {d, {(4 * PREG_W){1'b0}}};
        if (d.valid) begin
            if (d.src1_is_reg) begin
                r.prs1 = model_rat[d.lrs1];
            end
            if (d.src2_is_reg) begin
                r.prs2 = model_rat[d.lrs2];
            end
            if (d.need_to_wb) begin
                r.old_prd = model_rat[d.lrd];
                r.prd = free_q.pop_front();
                model_rat[d.lrd] = r.prd;
            end
        end
        return r;
    endfunction

    function automatic renamed_pair_t predict_pair(input decoded_pair_t d);
        renamed_pair_t r;
        r.slot0 = predict_slot(d.slot0);
        r.slot1 = predict_slot(d.slot1);
        return r;
    endfunction

    function automatic decoded_instr_t make_instr(input bit valid, input int lrd,
                                                  input int lrs1, input int lrs2, input bit wb);
        decoded_instr_t d;
        d = '0;
        d.valid = valid;
        d.pc = pc_next;
        d.lrd = lreg_t'(lrd);
        d.lrs1 = lreg_t'(lrs1);
        d.lrs2 = lreg_t'(lrs2);
        d.instr = {7'b0, d.lrs2, d.lrs1, 3'b0, d.lrd, 7'h33};
        d.imm = pc_next ^ 64'h00ff_00ff_00ff_00ff;
        d.src1_is_reg = 1'b1;
        d.src2_is_reg = 1'b1;
        d.need_to_wb = wb;
        d.alu_type = 4'(lrd);
        pc_next = pc_next + 64'd4;
        return d;
    endfunction

    function automatic decoded_pair_t random_pair();
        decoded_pair_t p;
        p.slot0 = make_instr(1'b1, $random(seed) & 31, $random(seed) & 31,
                             $random(seed) & 31, 1'b1);
        p.slot1 = make_instr(1'b1, $random(seed) & 31, $random(seed) & 31,
                             $random(seed) & 31, 1'b1);
        return p;
    endfunction

    // holds the pair until dec_ready is seen in the low phase
    task automatic send_pair(input decoded_pair_t p);
        @(negedge clock);
        dec_valid = 1'b1;
        dec_pair = p;
        #1;
        while (!dec_ready) begin
            @(negedge clock);
            #1;
        end
        sent_q.push_back(p);
    endtask

    task automatic end_send();
        @(negedge clock);
        dec_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int target);
        while (recv_count < target) begin
            @(negedge clock);
        end
    endtask

    task automatic release_reg(input preg_t r);
        @(negedge clock);
        release_valid = 1'b1;
        release_preg = r;
        @(negedge clock);
        release_valid = 1'b0;
        free_q.push_back(r);
        in_use[r] = 1'b0;
    endtask

    task automatic apply_flush();
        @(negedge clock);
        flush_valid = 1'b1;
        @(negedge clock);
        flush_valid = 1'b0;
        reset_model();
    endtask

    task automatic handle_output();
        renamed_pair_t  got;
        renamed_pair_t  exp;
        renamed_instr_t s [2];
        got = rn_pair;
        if (sent_q.size() == 0) begin
            $display("rn_valid was high with no pair outstanding");
            stop_run();
        end
        exp = predict_pair(sent_q.pop_front());
        check_pair(got, exp, "renamed pair");
        s[0] = got.slot0;
        s[1] = got.slot1;
        for (int i = 0; i < 2; i++) begin
            if (s[i].valid && s[i].need_to_wb) begin
                check_flag(in_use[s[i].prd], 1'b0,
                           $sformatf("preg %0d allocated twice", s[i].prd));
                in_use[s[i].prd] = 1'b1;
                retire_q.push_back(s[i].old_prd);
            end
        end
        last_rx = got;
        recv_count++;
    endtask

    task automatic rename_independent_pair();
        decoded_pair_t p;
        int base;
        base = recv_count;
        check_flag(rn_valid, 1'b0, "rn_valid after reset");
        check_flag(dec_ready, 1'b1, "dec_ready after reset");
        p.slot0 = make_instr(1'b1, 1, 2, 3, 1'b1);
        p.slot1 = make_instr(1'b1, 4, 5, 6, 1'b1);
        send_pair(p);
        end_send();
        #1;
        // one edge after acceptance the pair is still in the input register
        check_flag(rn_valid, 1'b0, "rn_valid one cycle after acceptance");
        @(negedge clock);
        #1;
        check_flag(rn_valid, 1'b1, "rn_valid two cycles after acceptance");
        wait_outputs(base + 1);
        check_preg(last_rx.slot0.prd, 6'd32, "first slot0 prd");
        check_preg(last_rx.slot1.prd, 6'd33, "first slot1 prd");
        check_preg(last_rx.slot0.prs1, 6'd2, "identity prs1");
        check_preg(last_rx.slot1.old_prd, 6'd4, "identity old_prd");
    endtask

    task automatic bypass_read_after_write();
        decoded_pair_t p;
        int base;
        base = recv_count;
        p.slot0 = make_instr(1'b1, 7, 1, 2, 1'b1);
        p.slot1 = make_instr(1'b1, 8, 7, 7, 1'b1);
        send_pair(p);
        end_send();
        wait_outputs(base + 1);
        // x7 gets 34 and x8 gets 35 after the first pair took 32 and 33
        check_preg(last_rx.slot1.prs1, 6'd34, "bypassed slot1 prs1");
        check_preg(last_rx.slot1.prs2, 6'd34, "bypassed slot1 prs2");
        // slot 1 here does not write back
        p.slot0 = make_instr(1'b1, 9, 7, 8, 1'b1);
        p.slot1 = make_instr(1'b1, 10, 9, 8, 1'b0);
        send_pair(p);
        end_send();
        wait_outputs(base + 2);
        check_preg(last_rx.slot0.prs1, 6'd34, "later read of x7");
        check_preg(last_rx.slot0.prs2, 6'd35, "later read of x8");
    endtask

    task automatic collapse_write_after_write();
        decoded_pair_t p;
        int base;
        base = recv_count;
        // 36 went to x9, so slot 0 gets 37 and slot 1 gets 38
        p.slot0 = make_instr(1'b1, 11, 1, 2, 1'b1);
        p.slot1 = make_instr(1'b1, 11, 3, 4, 1'b1);
        send_pair(p);
        end_send();
        wait_outputs(base + 1);
        check_preg(last_rx.slot1.old_prd, 6'd37, "waw slot1 old_prd");
        p.slot0 = make_instr(1'b1, 12, 11, 11, 1'b1);
        p.slot1 = make_instr(1'b0, 13, 11, 11, 1'b1);
        send_pair(p);
        end_send();
        wait_outputs(base + 2);
        check_preg(last_rx.slot0.prs1, 6'd38, "read after waw");
    endtask

    task automatic hold_under_back_pressure();
        renamed_pair_t snap;
        int base;
        base = recv_count;
        @(negedge clock);
        rn_ready = 1'b0;
        send_pair(random_pair());
        send_pair(random_pair());
        fork
            begin
                send_pair(random_pair());
                end_send();
            end
            begin
                @(negedge clock);
                #1;
                snap = rn_pair;
                check_flag(rn_valid, 1'b1, "rn_valid under back-pressure");
                repeat (3) begin
                    @(negedge clock);
                    #1;
                    check_pair(rn_pair, snap, "held rn_pair");
                end
                check_flag(dec_ready, 1'b0, "dec_ready under back-pressure");
                @(negedge clock);
                rn_ready = 1'b1;
            end
        join
        wait_outputs(base + 3);
    endtask

    task automatic exhaust_and_release();
        int base;
        int pairs;
        base = recv_count;
        pairs = free_q.size() / 2;
        repeat (pairs) send_pair(random_pair());
        // this pair waits in the input register for free registers
        send_pair(random_pair());
        fork
            begin
                send_pair(random_pair());
                end_send();
            end
            begin
                wait_outputs(base + pairs);
                repeat (3) @(negedge clock);
                #1;
                check_flag(dec_ready, 1'b0, "dec_ready with free list empty");
                check_flag(rn_valid, 1'b0, "rn_valid with free list empty");
                // the first four feed the two waiting pairs, the rest stay free
                repeat (8) release_reg(retire_q.pop_front());
            end
        join
        wait_outputs(base + pairs + 2);
    endtask

    task automatic flush_mid_stream();
        decoded_pair_t p;
        int base;
        @(negedge clock);
        rn_ready = 1'b0;
        send_pair(random_pair());
        send_pair(random_pair());
        end_send();
        repeat (2) @(negedge clock);
        #1;
        check_flag(rn_valid, 1'b1, "rn_valid before flush");
        check_flag(dec_ready, 1'b0, "dec_ready before flush");
        apply_flush();
        rn_ready = 1'b1;
        #1;
        check_flag(rn_valid, 1'b0, "rn_valid after flush");
        check_flag(dec_ready, 1'b1, "dec_ready after flush");
        base = recv_count;
        p.slot0 = make_instr(1'b1, 13, 5, 6, 1'b1);
        p.slot1 = make_instr(1'b1, 14, 13, 2, 1'b1);
        send_pair(p);
        end_send();
        wait_outputs(base + 1);
        check_preg(last_rx.slot0.prd, 6'd32, "prd after flush");
        check_preg(last_rx.slot0.prs1, 6'd5, "identity after flush");
        check_preg(last_rx.slot1.prs1, 6'd32, "bypass after flush");
    endtask

    // output monitor, sampled in the low phase
    initial begin
        forever begin
            @(negedge clock);
            #1;
            if (rst_n && rn_valid && rn_ready) begin
                handle_output();
            end
        end
    end

    initial begin
        #(CLK_PERIOD_NS * WATCHDOG_CYCLES);
        $display("timeout: the run hung after %0d cycles", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin
        dec_valid = 1'b0;
        dec_pair = '0;
        rn_ready = 1'b1;
        flush_valid = 1'b0;
        release_valid = 1'b0;
        release_preg = '0;
        reset_model();
        wait (rst_n === 1'b1);
        rename_independent_pair();
        bypass_read_after_write();
        collapse_write_after_write();
        hold_under_back_pressure();
        exhaust_and_release();
        flush_mid_stream();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/rename_pkg.sv
hdl/pipe_reg.sv
hdl/hazard_checker.sv
hdl/spec_rat.sv
hdl/free_list.sv
hdl/rename.sv
hdl/rename_top.sv
tests/clock_gen.sv
tests/tb_rename_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the rename slice testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_rename_top \
    -f sim.f \
    -Mdir "$BUILD_DIR" \
    -o tb_sim
if [ $? -ne 0 ]; then
    echo "run_sim: verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Errors found" "$LOG_FILE"; then
    echo "run_sim: simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulator exited with status $sim_status"
    exit 1
fi

echo "run_sim: simulation passed"
exit 0
